/* verilog/dcache_pkg.sv */
`default_nettype none

package dcache_pkg;

    parameter int ADDR_W                = 32;
    parameter int WORD_W                = 32;
    parameter int STRB_W                = 4;
    parameter int DEF_INDEX_WIDTH       = 4;    // 16 sets per way
    parameter int DEF_WORD_OFFSET_WIDTH = 2;    // 4 words per line

    typedef logic [ADDR_W-1:0] addr_t;          // byte address
    typedef logic [WORD_W-1:0] word_t;
    typedef logic [STRB_W-1:0] strb_t;          // all zero means a read
    typedef logic              way_t;

    // main miss/refill controller
    typedef enum logic [1:0] {
        IDLE,
        MISS,
        REFILL,
        WAIT_WRITE
    } ctrl_state_e;

    // dirty line eviction
    typedef enum logic [1:0] {
        WB_IDLE,
        WB_WRITE,
        WB_DONE
    } wb_state_e;

endpackage

`default_nettype wire

/* verilog/dcache_ways.sv */
`timescale 1ns/1ps
`default_nettype none

module dcache_ways #(
    parameter  int INDEX_WIDTH       = dcache_pkg::DEF_INDEX_WIDTH,
    parameter  int WORD_OFFSET_WIDTH = dcache_pkg::DEF_WORD_OFFSET_WIDTH,
    localparam int LINE_W            = dcache_pkg::WORD_W << WORD_OFFSET_WIDTH,
    localparam int TAG_W = dcache_pkg::ADDR_W - INDEX_WIDTH - WORD_OFFSET_WIDTH - 2
) (
    input  logic              clk,
    input  logic              rstn,
    input  dcache_pkg::addr_t addr,         // live address, read side
    input  dcache_pkg::addr_t req_addr,     // buffered address, write and compare side
    input  logic              hit_we,
    input  logic              refill_we,
    input  dcache_pkg::way_t  hit_way,
    input  dcache_pkg::way_t  victim_way,
    input  dcache_pkg::strb_t wstrb,
    input  logic [LINE_W-1:0] line_wdata,
    output logic              hit,
    output dcache_pkg::way_t  hit_way_out,
    output logic [LINE_W-1:0] way_rdata0,
    output logic [LINE_W-1:0] way_rdata1,
    output logic [TAG_W-1:0]  victim_tag
);
    import dcache_pkg::*;

    localparam int BYTE_OFF   = WORD_OFFSET_WIDTH + 2;
    localparam int SETS       = 1 << INDEX_WIDTH;
    localparam int LINE_BYTES = LINE_W / 8;

    logic [INDEX_WIDTH-1:0] r_index, w_index;
    logic [TAG_W-1:0]       req_tag;
    logic [LINE_BYTES-1:0]  hit_be;
    logic [1:0]             match;

    assign r_index = addr[BYTE_OFF +: INDEX_WIDTH];
    assign w_index = req_addr[BYTE_OFF +: INDEX_WIDTH];
    assign req_tag = req_addr[ADDR_W-1 -: TAG_W];
    assign hit_be  = LINE_BYTES'(wstrb) << (req_addr[BYTE_OFF-1:2] * STRB_W);

    //////////////////////////////
    // per-way storage
    for (genvar w = 0; w < 2; w++) begin : g_way
        logic [LINE_W-1:0]     data_mem [SETS];
        logic [TAG_W-1:0]      tag_mem [SETS];
        logic [SETS-1:0]       valid_mem;
        logic [LINE_BYTES-1:0] be;
        logic [LINE_W-1:0]     rd_next;
        logic [LINE_W-1:0]     line_q;
        logic [TAG_W-1:0]      tag_q;
        logic                  valid_q;
        logic                  fill;

        assign fill = refill_we && (victim_way == w);

        always_comb begin
            if (fill) begin
                be = '1;
            end else if (hit_we && (hit_way == w)) begin
                be = hit_be;
            end else begin
                be = '0;
            end
        end

        // write-first, new bytes bypass to the read port
        always_comb begin
            rd_next = data_mem[r_index];
            for (int b = 0; b < LINE_BYTES; b++) begin
                if (be[b] && (r_index == w_index)) begin
                    rd_next[8*b +: 8] = line_wdata[8*b +: 8];
                end
            end
        end

        always_ff @(posedge clk) begin
            for (int b = 0; b < LINE_BYTES; b++) begin
                if (be[b]) begin
                    data_mem[w_index][8*b +: 8] <= line_wdata[8*b +: 8];
                end
            end
            if (fill) begin
                tag_mem[w_index] <= req_tag;
            end
            line_q <= rd_next;
            tag_q  <= tag_mem[r_index];
        end

        always_ff @(posedge clk) begin
            if (!rstn) begin
                valid_mem <= '0;
                valid_q   <= 1'b0;
            end else begin
                if (fill) begin
                    valid_mem[w_index] <= 1'b1;
                end
                valid_q <= valid_mem[r_index];
            end
        end

        assign match[w] = valid_q && (tag_q == req_tag);
    end

    assign hit         = match[0];
    assign hit_way_out = match[1];      // a line never sits in both ways
    assign way_rdata0  = g_way[0].line_q;
    assign way_rdata1  = g_way[1].line_q;
    assign victim_tag  = victim_way ? g_way[1].tag_q : g_way[0].tag_q;

endmodule

`default_nettype wire

/* verilog/replace_dirty.sv */
`timescale 1ns/1ps
`default_nettype none

module replace_dirty #(
    parameter int INDEX_WIDTH = dcache_pkg::DEF_INDEX_WIDTH
) (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic [INDEX_WIDTH-1:0] set_index,
    input  dcache_pkg::way_t       hit_way,
    input  logic                   lru_hit_update,
    input  logic                   lru_refill_update,
    input  logic                   dirty_set,
    input  logic                   dirty_refill,
    input  logic                   req_write,
    output dcache_pkg::way_t       victim_way,
    output logic                   victim_dirty
);
    import dcache_pkg::*;

    localparam int SETS = 1 << INDEX_WIDTH;

    logic [SETS-1:0] lru;               // most recently used way per set
    logic [SETS-1:0] dirty [2];
    way_t            mru;

    assign mru          = lru[set_index];
    assign victim_way   = ~mru;
    assign victim_dirty = dirty[victim_way][set_index];

    always_ff @(posedge clk) begin
        if (!rstn) begin
            lru      <= '0;
            dirty[0] <= '0;
            dirty[1] <= '0;
        end else begin
            if (lru_hit_update) begin
                lru[set_index] <= hit_way;
            end else if (lru_refill_update) begin
                lru[set_index] <= victim_way;   // refilled way becomes mru
            end
            if (dirty_refill) begin
                dirty[victim_way][set_index] <= req_write;
            end else if (dirty_set) begin
                dirty[hit_way][set_index] <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/dcache_datapath.sv */
`timescale 1ns/1ps
`default_nettype none

module dcache_datapath #(
    parameter  int INDEX_WIDTH       = dcache_pkg::DEF_INDEX_WIDTH,
    parameter  int WORD_OFFSET_WIDTH = dcache_pkg::DEF_WORD_OFFSET_WIDTH,
    localparam int LINE_W            = dcache_pkg::WORD_W << WORD_OFFSET_WIDTH,
    localparam int TAG_W = dcache_pkg::ADDR_W - INDEX_WIDTH - WORD_OFFSET_WIDTH - 2
) (
    input  logic              clk,
    input  logic              rstn,
    input  dcache_pkg::addr_t addr,
    input  dcache_pkg::word_t wdata,
    input  dcache_pkg::strb_t wstrb,
    input  logic              rvalid,
    input  logic              wvalid,
    input  logic              req_buf_we,
    input  logic              line_buf_we,
    input  logic              wb_shift,
    input  logic              from_return,
    input  logic              mem_beat,
    input  dcache_pkg::word_t mem_rdata,
    input  logic [LINE_W-1:0] way_rdata0,
    input  logic [LINE_W-1:0] way_rdata1,
    input  dcache_pkg::way_t  victim_way,
    input  dcache_pkg::way_t  hit_way,
    input  logic [TAG_W-1:0]  victim_tag,
    output dcache_pkg::addr_t req_addr,
    output dcache_pkg::addr_t mem_raddr,
    output dcache_pkg::addr_t mem_waddr,
    output logic              req_valid,
    output logic              req_write,
    output dcache_pkg::strb_t req_strb,
    output logic [LINE_W-1:0] line_wdata,
    output dcache_pkg::word_t rdata,
    output dcache_pkg::word_t mem_wdata
);
    import dcache_pkg::*;

    localparam int BYTE_OFF = WORD_OFFSET_WIDTH + 2;

    word_t                        req_wdata, wmask_word;
    addr_t                        miss_addr;
    logic [WORD_OFFSET_WIDTH-1:0] word_off;
    logic [LINE_W-1:0]            ret_buf, wb_buf, wdata_line, wmask_line, rd_line;

    //////////////////////////////
    // request buffer
    always_ff @(posedge clk) begin
        if (!rstn) begin
            req_valid <= 1'b0;
            req_write <= 1'b0;
        end else if (req_buf_we) begin
            req_valid <= rvalid | wvalid;
            req_write <= wvalid && (|wstrb);
        end
    end

    always_ff @(posedge clk) begin
        if (req_buf_we) begin
            req_addr  <= addr;
            req_wdata <= wdata;
            req_strb  <= wstrb;
        end
    end

    //////////////////////////////
    // return, write-back and miss-address buffers
    always_ff @(posedge clk) begin
        if (mem_beat) begin
            ret_buf <= {mem_rdata, ret_buf[LINE_W-1:WORD_W]};  // first beat ends up lowest
        end
        if (line_buf_we) begin
            wb_buf    <= victim_way ? way_rdata1 : way_rdata0;
            miss_addr <= {victim_tag, req_addr[BYTE_OFF +: INDEX_WIDTH], {BYTE_OFF{1'b0}}};
        end else if (wb_shift) begin
            wb_buf <= wb_buf >> WORD_W;
        end
    end

    assign mem_raddr = {req_addr[ADDR_W-1:BYTE_OFF], {BYTE_OFF{1'b0}}};
    assign mem_waddr = miss_addr;
    assign mem_wdata = wb_buf[WORD_W-1:0];

    //////////////////////////////
    // write merge and read select
    assign word_off = req_addr[BYTE_OFF-1:2];

    always_comb begin
        for (int b = 0; b < STRB_W; b++) begin
            wmask_word[8*b +: 8] = {8{req_strb[b]}};
        end
    end

    assign wdata_line = LINE_W'(req_wdata) << (word_off * WORD_W);
    assign wmask_line = LINE_W'(wmask_word) << (word_off * WORD_W);
    // also the hit write data, the ways only enable the strobed bytes
    assign line_wdata = (ret_buf & ~wmask_line) | (wdata_line & wmask_line);

    assign rd_line = from_return ? ret_buf : (hit_way ? way_rdata1 : way_rdata0);
    assign rdata   = rd_line[word_off*WORD_W +: WORD_W];

endmodule

`default_nettype wire

/* verilog/writeback_engine.sv */
`timescale 1ns/1ps
`default_nettype none

module writeback_engine #(
    parameter int WORD_OFFSET_WIDTH = dcache_pkg::DEF_WORD_OFFSET_WIDTH
) (
    input  logic clk,
    input  logic rstn,
    input  logic wb_start,
    input  logic victim_dirty,
    input  logic ctrl_waiting,      // controller sits in WAIT_WRITE
    input  logic mem_wready,
    input  logic mem_bvalid,
    output logic mem_wvalid,
    output logic mem_wlast,
    output logic mem_bready,
    output logic wb_shift,
    output logic wb_done
);
    import dcache_pkg::*;

    localparam int BEATS = 1 << WORD_OFFSET_WIDTH;

    wb_state_e                state, next_state;
    logic [WORD_OFFSET_WIDTH:0] beat_cnt;         // msb set once all beats went out
    logic                     beats_sent;

    assign beats_sent = beat_cnt[WORD_OFFSET_WIDTH];
    assign mem_wvalid = (state == WB_WRITE) && !beats_sent;
    assign mem_wlast  = mem_wvalid && (beat_cnt == (WORD_OFFSET_WIDTH+1)'(BEATS - 1));
    assign mem_bready = (state == WB_WRITE) && beats_sent;
    assign wb_shift   = mem_wvalid && mem_wready;
    assign wb_done    = (state == WB_DONE);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state    <= WB_IDLE;
            beat_cnt <= '0;
        end else begin
            state <= next_state;
            if (state == WB_IDLE) begin
                beat_cnt <= '0;
            end else if (wb_shift) begin
                beat_cnt <= beat_cnt + 1'b1;
            end
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            WB_IDLE:  if (wb_start) next_state = victim_dirty ? WB_WRITE : WB_DONE;
            WB_WRITE: if (mem_bready && mem_bvalid) next_state = WB_DONE;
            WB_DONE:  if (ctrl_waiting) next_state = WB_IDLE;   // hold until consumed
            default:  next_state = WB_IDLE;
        endcase
    end

endmodule

`default_nettype wire

/* verilog/dcache_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module dcache_ctrl (
    input  logic             clk,
    input  logic             rstn,
    input  logic             req_valid,
    input  logic             req_write,
    input  logic             hit,           // way 0 tag match
    input  logic             mem_rready,
    input  logic             mem_rlast,
    input  logic             wb_done,
    input  dcache_pkg::way_t hit_way,       // way 1 tag match, also the hit way
    output logic             req_buf_we,
    output logic             way_hit_we,
    output logic             way_refill_we,
    output logic             lru_hit_update,
    output logic             lru_refill_update,
    output logic             dirty_set,
    output logic             dirty_refill,
    output logic             line_buf_we,
    output logic             from_return,
    output logic             mem_rvalid,
    output logic             wb_start,
    output logic             dcache_miss
);
    import dcache_pkg::*;

    ctrl_state_e state, next_state;
    logic        lookup_hit;

    assign lookup_hit = hit | hit_way;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state        = state;
        req_buf_we        = 1'b0;
        way_hit_we        = 1'b0;
        way_refill_we     = 1'b0;
        lru_hit_update    = 1'b0;
        lru_refill_update = 1'b0;
        dirty_set         = 1'b0;
        dirty_refill      = 1'b0;
        line_buf_we       = 1'b0;
        from_return       = 1'b0;
        mem_rvalid        = 1'b0;
        wb_start          = 1'b0;
        dcache_miss       = 1'b0;
        case (state)
            IDLE: begin
                if (!req_valid) begin
                    req_buf_we = 1'b1;              // nothing buffered, keep accepting
                end else if (lookup_hit) begin
                    req_buf_we     = 1'b1;
                    way_hit_we     = req_write;     // byte enables come from the ways
                    lru_hit_update = 1'b1;
                    dirty_set      = req_write;
                end else begin
                    // grab victim line and its address before the arrays move on
                    line_buf_we = 1'b1;
                    wb_start    = 1'b1;
                    dcache_miss = 1'b1;
                    next_state  = MISS;
                end
            end
            MISS: begin
                mem_rvalid  = 1'b1;
                dcache_miss = 1'b1;
                if (mem_rready && mem_rlast) begin
                    next_state = REFILL;
                end
            end
            REFILL: begin
                way_refill_we     = 1'b1;           // merged line, tag and valid
                lru_refill_update = 1'b1;
                dirty_refill      = 1'b1;
                dcache_miss       = 1'b1;
                next_state        = WAIT_WRITE;
            end
            WAIT_WRITE: begin
                from_return = 1'b1;
                dcache_miss = !wb_done;
                req_buf_we  = wb_done;
                if (wb_done) begin
                    next_state = IDLE;
                end
            end
            default: next_state = IDLE;
        endcase
    end

endmodule

`default_nettype wire

/* verilog/dcache_top.sv */
`timescale 1ns/1ps
`default_nettype none

module dcache_top #(
    parameter int INDEX_WIDTH       = dcache_pkg::DEF_INDEX_WIDTH,
    parameter int WORD_OFFSET_WIDTH = dcache_pkg::DEF_WORD_OFFSET_WIDTH
) (
    input  logic              clk,
    input  logic              rstn,
    // pipeline side
    input  dcache_pkg::addr_t addr,
    input  logic              rvalid,
    input  logic              wvalid,
    input  dcache_pkg::word_t wdata,
    input  dcache_pkg::strb_t wstrb,
    output dcache_pkg::word_t rdata,
    output logic              dcache_miss,
    // memory read channel
    output logic              mem_rvalid,
    input  logic              mem_rready,
    input  logic              mem_rlast,
    output dcache_pkg::addr_t mem_raddr,
    input  dcache_pkg::word_t mem_rdata,
    // memory write channel
    output logic              mem_wvalid,
    output logic              mem_wlast,
    output logic              mem_bready,
    input  logic              mem_wready,
    input  logic              mem_bvalid,
    output dcache_pkg::addr_t mem_waddr,
    output dcache_pkg::word_t mem_wdata
);
    import dcache_pkg::*;

    localparam int BYTE_OFF = WORD_OFFSET_WIDTH + 2;
    localparam int LINE_W   = WORD_W << WORD_OFFSET_WIDTH;
    localparam int TAG_W    = ADDR_W - INDEX_WIDTH - BYTE_OFF;

    logic req_buf_we, way_hit_we, way_refill_we, line_buf_we, from_return;
    logic lru_hit_update, lru_refill_update, dirty_set, dirty_refill;
    logic wb_start, wb_done, wb_shift, mem_beat;
    logic hit, victim_dirty, req_valid, req_write;
    way_t hit_way, victim_way;
    addr_t req_addr;
    strb_t req_strb;
    logic [LINE_W-1:0] line_wdata, way_rdata0, way_rdata1;
    logic [TAG_W-1:0]  victim_tag;

    assign mem_beat = mem_rvalid & mem_rready;

    dcache_ctrl u_ctrl (
        .clk(clk), .rstn(rstn),
        .req_valid(req_valid), .req_write(req_write), .hit(hit), .hit_way(hit_way),
        .mem_rready(mem_rready), .mem_rlast(mem_rlast), .wb_done(wb_done),
        .req_buf_we(req_buf_we), .way_hit_we(way_hit_we), .way_refill_we(way_refill_we),
        .lru_hit_update(lru_hit_update), .lru_refill_update(lru_refill_update),
        .dirty_set(dirty_set), .dirty_refill(dirty_refill), .line_buf_we(line_buf_we),
        .from_return(from_return), .mem_rvalid(mem_rvalid), .wb_start(wb_start),
        .dcache_miss(dcache_miss)
    );

    writeback_engine #(.WORD_OFFSET_WIDTH(WORD_OFFSET_WIDTH)) u_wb (
        .clk(clk), .rstn(rstn),
        .wb_start(wb_start), .victim_dirty(victim_dirty), .ctrl_waiting(from_return),
        .mem_wready(mem_wready), .mem_bvalid(mem_bvalid),
        .mem_wvalid(mem_wvalid), .mem_wlast(mem_wlast), .mem_bready(mem_bready),
        .wb_shift(wb_shift), .wb_done(wb_done)
    );

    dcache_ways #(.INDEX_WIDTH(INDEX_WIDTH), .WORD_OFFSET_WIDTH(WORD_OFFSET_WIDTH)) u_ways (
        .clk(clk), .rstn(rstn),
        .addr(addr), .req_addr(req_addr),
        .hit_we(way_hit_we), .refill_we(way_refill_we),
        .hit_way(hit_way), .victim_way(victim_way),
        .wstrb(req_strb), .line_wdata(line_wdata),
        .hit(hit), .hit_way_out(hit_way),
        .way_rdata0(way_rdata0), .way_rdata1(way_rdata1), .victim_tag(victim_tag)
    );

    replace_dirty #(.INDEX_WIDTH(INDEX_WIDTH)) u_repl (
        .clk(clk), .rstn(rstn),
        .set_index(req_addr[BYTE_OFF +: INDEX_WIDTH]), .hit_way(hit_way),
        .lru_hit_update(lru_hit_update), .lru_refill_update(lru_refill_update),
        .dirty_set(dirty_set), .dirty_refill(dirty_refill), .req_write(req_write),
        .victim_way(victim_way), .victim_dirty(victim_dirty)
    );

    dcache_datapath #(.INDEX_WIDTH(INDEX_WIDTH), .WORD_OFFSET_WIDTH(WORD_OFFSET_WIDTH)) u_dp (
        .clk(clk), .rstn(rstn),
        .addr(addr), .wdata(wdata), .wstrb(wstrb), .rvalid(rvalid), .wvalid(wvalid),
        .req_buf_we(req_buf_we), .line_buf_we(line_buf_we), .wb_shift(wb_shift),
        .from_return(from_return), .mem_beat(mem_beat), .mem_rdata(mem_rdata),
        .way_rdata0(way_rdata0), .way_rdata1(way_rdata1),
        .victim_way(victim_way), .hit_way(hit_way), .victim_tag(victim_tag),
        .req_addr(req_addr), .mem_raddr(mem_raddr), .mem_waddr(mem_waddr),
        .req_valid(req_valid), .req_write(req_write), .req_strb(req_strb),
        .line_wdata(line_wdata), .rdata(rdata), .mem_wdata(mem_wdata)
    );

endmodule

`default_nettype wire

/* bench/tb_dcache_tasks.svh */
`ifndef TB_DCACHE_TASKS_SVH
`define TB_DCACHE_TASKS_SVH

// one 32-bit xorshift step
function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
endfunction

// power-up contents built from every address bit
function automatic logic [7:0] fill_byte(input int a);
    logic [11:0] b;
    b = a[11:0];
    return b[7:0] ^ {b[3:0], b[11:8]};
endfunction

//////////////////////////////
// error reporting
task automatic halt_on_error();
    $display("TESTS FAILED");
    $fatal(1, "stopped at the first error");
endtask

task automatic abort_run(input string why);
    $display("error at %0d ns: %s", $time, why);
    halt_on_error();
endtask

task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
        $display("[FAIL] %0d ns %s: got %h, expected %h", $time, name, got, exp);
        halt_on_error();
    end
endtask

task automatic check_addr(input string name, input addr_t got, input addr_t exp);
    if (got !== exp) begin
        $display("[FAIL] %0d ns %s: got %h, expected %h", $time, name, got, exp);
        halt_on_error();
    end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
        $display("[FAIL] %0d ns %s: got %b, expected %b", $time, name, got, exp);
        halt_on_error();
    end
endtask

//////////////////////////////
// reference model
addr_t      m_tag   [0:1][0:SETS-1];    // address bits above the index
logic       m_valid [0:1][0:SETS-1];
logic       m_dirty [0:1][0:SETS-1];
logic       m_mru   [0:SETS-1];
logic [7:0] ref_img [0:MEM_BYTES-1];    // latest byte image seen by the pipeline

task automatic model_reset();
    int s;
    int a;
    for (s = 0; s < SETS; s++) begin
        m_tag[0][s]   = '0;
        m_tag[1][s]   = '0;
        m_valid[0][s] = 1'b0;
        m_valid[1][s] = 1'b0;
        m_dirty[0][s] = 1'b0;
        m_dirty[1][s] = 1'b0;
        m_mru[s]      = 1'b0;
    end
    for (a = 0; a < MEM_BYTES; a++) begin
        ref_img[a] = fill_byte(a);
    end
endtask

function automatic word_t ref_word(input addr_t a);
    word_t w;
    int    k;
    for (k = 0; k < 4; k++) begin
        w[8*k +: 8] = ref_img[a[11:0] + k];
    end
    return w;
endfunction

// one accepted request and the bursts it must cause
task automatic model_access(input addr_t a, input logic wr, input strb_t strb,
                            input word_t wd, output logic hit, output word_t rd);
    int    idx;
    int    way;
    int    b;
    addr_t tag;
    addr_t victim_base;
    idx = int'((a >> BYTE_OFF) & addr_t'(SETS - 1));
    tag = a >> (BYTE_OFF + INDEX_W);
    hit = 1'b0;
    way = 0;
    if (m_valid[0][idx] && (m_tag[0][idx] == tag)) begin
        hit = 1'b1;
    end else if (m_valid[1][idx] && (m_tag[1][idx] == tag)) begin
        hit = 1'b1;
        way = 1;
    end
    if (!hit) begin
        way = m_mru[idx] ? 0 : 1;     // victim is the non-mru way
        exp_raddr.push_back(a & ~addr_t'(LINE_BYTES - 1));
        if (m_dirty[way][idx]) begin
            victim_base = (m_tag[way][idx] << (BYTE_OFF + INDEX_W)) | addr_t'(idx << BYTE_OFF);
            exp_waddr.push_back(victim_base);
            for (b = 0; b < BEATS; b++) begin
                exp_wdata.push_back(ref_word(victim_base + addr_t'(4 * b)));
            end
        end
        m_tag[way][idx]   = tag;
        m_valid[way][idx] = 1'b1;
        m_dirty[way][idx] = 1'b0;
    end
    m_mru[idx] = (way == 1);
    if (wr) begin
        m_dirty[way][idx] = 1'b1;
        for (b = 0; b < 4; b++) begin
            if (strb[b]) ref_img[a[11:0] + b] = wd[8*b +: 8];
        end
    end
    rd = ref_word(a);
endtask

`endif

/* bench/tb_dcache.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_dcache;
    import dcache_pkg::*;

    localparam int INDEX_W       = DEF_INDEX_WIDTH;
    localparam int OFF_W         = DEF_WORD_OFFSET_WIDTH;
    localparam int BYTE_OFF      = OFF_W + 2;
    localparam int SETS          = 1 << INDEX_W;
    localparam int BEATS         = 1 << OFF_W;
    localparam int LINE_BYTES    = 4 * BEATS;
    localparam int MEM_BYTES     = 4096;        // 4 KB address window
    localparam int NUM_OPS       = 2000;
    localparam int CYCLES_PER_OP = 60;
    localparam int RESET_CYCLES  = 5;

    logic  clk;
    logic  rstn;
    addr_t addr;
    logic  rvalid;
    logic  wvalid;
    word_t wdata;
    strb_t wstrb;
    word_t rdata;
    logic  dcache_miss;
    logic  mem_rvalid;
    logic  mem_rready;
    logic  mem_rlast;
    addr_t mem_raddr;
    word_t mem_rdata;
    logic  mem_wvalid;
    logic  mem_wlast;
    logic  mem_bready;
    logic  mem_wready;
    logic  mem_bvalid;
    addr_t mem_waddr;
    word_t mem_wdata;

    // bursts the model expects, in order
    addr_t exp_raddr [$];
    addr_t exp_waddr [$];
    word_t exp_wdata [$];

    logic [31:0] stim_rng;
    logic [31:0] mem_rng;
    logic [7:0]  mem [0:MEM_BYTES-1];   // main memory behind the cache
    logic        rd_active;
    logic        wr_active;
    logic        wr_wait_b;             // all beats sent, response still owed
    int          rd_beat;
    int          wr_beat;
    addr_t       rd_base;
    addr_t       wr_base;

    `include "tb_dcache_tasks.svh"

    dcache_top #(.INDEX_WIDTH(INDEX_W), .WORD_OFFSET_WIDTH(OFF_W)) dut0 (
        .clk(clk), .rstn(rstn),
        .addr(addr), .rvalid(rvalid), .wvalid(wvalid), .wdata(wdata), .wstrb(wstrb),
        .rdata(rdata), .dcache_miss(dcache_miss),
        .mem_rvalid(mem_rvalid), .mem_rready(mem_rready), .mem_rlast(mem_rlast),
        .mem_raddr(mem_raddr), .mem_rdata(mem_rdata),
        .mem_wvalid(mem_wvalid), .mem_wlast(mem_wlast), .mem_bready(mem_bready),
        .mem_wready(mem_wready), .mem_bvalid(mem_bvalid),
        .mem_waddr(mem_waddr), .mem_wdata(mem_wdata)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic word_t mem_word(input addr_t a);
        word_t w;
        int    k;
        for (k = 0; k < 4; k++) begin
            w[8*k +: 8] = mem[a[11:0] + k];
        end
        return w;
    endfunction

    task automatic store_mem_word(input addr_t a, input word_t d);
        int k;
        for (k = 0; k < 4; k++) begin
            mem[a[11:0] + k] = d[8*k +: 8];
        end
    endtask

    // half the requests go to 32 lines that fit the cache, the rest thrash
    task automatic draw_op(output addr_t a, output logic wr, output strb_t s, output word_t d);
        logic [31:0] r;
        stim_rng = xorshift32(stim_rng);
        r        = stim_rng;
        wr       = r[0];
        a        = r[1] ? {23'h0, r[8:2], 2'b00} : {20'h0, r[11:2], 2'b00};
        s        = (r[15:12] == 4'h0) ? 4'h1 : r[15:12];
        stim_rng = xorshift32(stim_rng);
        d        = stim_rng;
    endtask

    //////////////////////////////
    // memory responder
    task automatic serve_read();
        addr_t beat_addr;
        if (mem_rvalid && !rd_active) begin
            if (exp_raddr.size() == 0) begin
                abort_run("read burst started without a cache miss");
            end else begin
                rd_base   = exp_raddr.pop_front();
                rd_beat   = 0;
                rd_active = 1'b1;
            end
        end
        if (rd_active) begin
            if (!mem_rvalid) begin
                abort_run("mem_rvalid dropped inside a read burst");
            end else begin
                check_addr("mem_raddr", mem_raddr, rd_base);
                mem_rng    = xorshift32(mem_rng);
                mem_rready = (mem_rng[1:0] != 2'b00);
                beat_addr  = rd_base + addr_t'(4 * rd_beat);
                mem_rdata  = mem_word(beat_addr);
                mem_rlast  = (rd_beat == BEATS - 1);
                if (mem_rready) begin
                    rd_beat   = rd_beat + 1;
                    rd_active = (rd_beat != BEATS);
                end
            end
        end else begin
            mem_rready = 1'b0;
            mem_rlast  = 1'b0;
        end
    endtask

    task automatic serve_write();
        word_t exp_w;
        mem_bvalid = 1'b0;
        if (mem_wvalid && !wr_active) begin
            if (wr_wait_b || (exp_waddr.size() == 0)) begin
                abort_run("write burst without a dirty victim");
            end else begin
                wr_base   = exp_waddr.pop_front();
                wr_beat   = 0;
                wr_active = 1'b1;
            end
        end
        if (wr_active) begin
            mem_rng    = xorshift32(mem_rng);
            mem_wready = (mem_rng[3:2] != 2'b00);
            if (!mem_wvalid) begin
                abort_run("mem_wvalid dropped inside a write burst");
            end else if (mem_wready) begin
                exp_w = exp_wdata.pop_front();
                check_addr("mem_waddr", mem_waddr, wr_base);
                check_word("mem_wdata", mem_wdata, exp_w);
                check_bit("mem_wlast", mem_wlast, wr_beat == BEATS - 1);
                store_mem_word(wr_base + addr_t'(4 * wr_beat), mem_wdata);
                wr_beat = wr_beat + 1;
                if (wr_beat == BEATS) begin
                    wr_active = 1'b0;
                    wr_wait_b = 1'b1;
                end
            end
        end else begin
            mem_wready = 1'b0;
            if (wr_wait_b && mem_bready) begin
                mem_rng    = xorshift32(mem_rng);
                mem_bvalid = mem_rng[4];        // response after a random delay
                wr_wait_b  = !mem_rng[4];
            end
        end
    endtask

    initial begin : mem_responder
        int a;
        mem_rng    = ~32'hc0cd;         // own stream, not tied to stimulus order
        mem_rready = 1'b0;
        mem_rlast  = 1'b0;
        mem_rdata  = '0;
        mem_wready = 1'b0;
        mem_bvalid = 1'b0;
        rd_active  = 1'b0;
        wr_active  = 1'b0;
        wr_wait_b  = 1'b0;
        rd_beat    = 0;
        wr_beat    = 0;
        for (a = 0; a < MEM_BYTES; a++) begin
            mem[a] = fill_byte(a);
        end
        forever begin
            @(negedge clk);
            if (rstn) begin
                serve_read();
                serve_write();
            end
        end
    end

    //////////////////////////////
    // stimulus and result checks
    initial begin : stimulus
        addr_t op_addr;
        logic  op_write;
        strb_t op_strb;
        word_t op_wdata;
        logic  pend;
        logic  pend_hit;
        logic  pend_read;
        word_t pend_rdata;
        logic  m_hit;
        word_t m_rd;
        int    i;
        rstn     = 1'b0;
        addr     = '0;
        rvalid   = 1'b0;
        wvalid   = 1'b0;
        wdata    = '0;
        wstrb    = '0;
        stim_rng = 32'hc0cd;
        pend     = 1'b0;
        model_reset();
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;
        @(negedge clk);
        check_bit("dcache_miss", dcache_miss, 1'b0);
        check_bit("mem_rvalid", mem_rvalid, 1'b0);
        check_bit("mem_wvalid", mem_wvalid, 1'b0);
        check_bit("mem_wlast", mem_wlast, 1'b0);
        check_bit("mem_bready", mem_bready, 1'b0);
        for (i = 0; i <= NUM_OPS; i++) begin
            if (i < NUM_OPS) begin
                draw_op(op_addr, op_write, op_strb, op_wdata);
                addr   = op_addr;
                rvalid = !op_write;
                wvalid = op_write;
                wdata  = op_wdata;
                wstrb  = op_write ? op_strb : 4'h0;
            end else begin
                rvalid = 1'b0;
                wvalid = 1'b0;
                wstrb  = 4'h0;
            end
            // first cycle after acceptance, a hit answers right here
            if (pend) check_bit("dcache_miss", dcache_miss, !pend_hit);
            while (dcache_miss) @(negedge clk);
            if (pend && pend_read) check_word("rdata", rdata, pend_rdata);
            if (i < NUM_OPS) begin
                model_access(op_addr, op_write, op_strb, op_wdata, m_hit, m_rd);
                pend       = 1'b1;
                pend_hit   = m_hit;
                pend_read  = !op_write;
                pend_rdata = m_rd;
            end
            @(negedge clk);
        end
        if ((exp_raddr.size() != 0) || (exp_waddr.size() != 0) || rd_active || wr_active) begin
            abort_run("expected memory bursts never happened");
        end else begin
            $display("TESTS PASSED");
            $finish;
        end
    end

    initial begin : watchdog
        repeat (RESET_CYCLES + 10 + NUM_OPS * CYCLES_PER_OP) @(posedge clk);
        $display("watchdog expired before all requests completed");
        $display("TESTS FAILED");
        $fatal(1, "timeout");
    end

endmodule

`default_nettype wire

/* flist.f */
+incdir+bench
verilog/dcache_pkg.sv
verilog/dcache_ways.sv
verilog/replace_dirty.sv
verilog/dcache_datapath.sv
verilog/writeback_engine.sv
verilog/dcache_ctrl.sv
verilog/dcache_top.sv
bench/tb_dcache.sv
